// ==== verilog/keccak_macros.svh ====
////////////////////////////////////////////////////////////
// Keccak-512 engine sizes
// state, rate, digest, rounds, message word, input credits
////////////////////////////////////////////////////////////
`ifndef KECCAK_MACROS_SVH
`define KECCAK_MACROS_SVH

// full Keccak-f[1600] state
`define KECCAK_STATE_W 1600

// rate for c = 1024, 18 words of 32 bits
`define KECCAK_RATE_W 576

// first 512 state bits form the hash
`define KECCAK_DIGEST_W 512

// rounds per permutation, one per cycle
`define KECCAK_ROUNDS 24

// message word from the source
`define KECCAK_WORD_W 32

// padder input buffer depth, source credits after reset
`define KECCAK_IN_CREDITS 4

`endif

// ==== verilog/keccak_pkg.sv ====
////////////////////////////////////////////////////////////
// Keccak-512 shared types
// message word, state views and rate block
////////////////////////////////////////////////////////////
`default_nettype none

`include "keccak_macros.svh"

package keccak_pkg;

    // one message word as streamed by the source
    typedef struct packed {
        logic [`KECCAK_WORD_W-1:0] data;     // first message byte in top byte
        logic                      last;     // final word of the message
        logic [1:0]                byte_num; // valid bytes in a final word, 0..3
    } msg_word_t;

    // permutation state, flat or as 25 lanes of 64 bits
    // lane index is x + 5y, lane 0 sits in the top bits
    // lane bit 0 is the lane LSB, bytes little-endian as in Keccak
    typedef union packed {
        logic [`KECCAK_STATE_W-1:0] flat;
        logic [0:24][63:0]          lane;
    } state_u;

    // one rate block, message byte order, byte 0 at the top
    typedef logic [`KECCAK_RATE_W-1:0] block_t;

endpackage

`default_nettype wire

// ==== verilog/keccak_rconst.sv ====
////////////////////////////////////////////////////////////
// Keccak iota round constant
// sparse OR decode of the one-hot round index
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "keccak_macros.svh"

module keccak_rconst (
    input  wire logic [`KECCAK_ROUNDS-1:0] round_onehot, // bit r = round r
    output logic [63:0]                    rc
);

    // only bits 0, 1, 3, 7, 15, 31 and 63 are ever set
    assign rc[0]  = round_onehot[0]  | round_onehot[4]  | round_onehot[5]  | round_onehot[6]
                  | round_onehot[7]  | round_onehot[10] | round_onehot[12] | round_onehot[13]
                  | round_onehot[14] | round_onehot[15] | round_onehot[20] | round_onehot[22];
    assign rc[1]  = round_onehot[1]  | round_onehot[2]  | round_onehot[4]  | round_onehot[8]
                  | round_onehot[11] | round_onehot[12] | round_onehot[13] | round_onehot[15]
                  | round_onehot[16] | round_onehot[18] | round_onehot[19];
    assign rc[2]  = 1'b0;
    assign rc[3]  = round_onehot[2]  | round_onehot[4]  | round_onehot[7]  | round_onehot[8]
                  | round_onehot[9]  | round_onehot[10] | round_onehot[11] | round_onehot[12]
                  | round_onehot[13] | round_onehot[14] | round_onehot[18] | round_onehot[19]
                  | round_onehot[23];
    assign rc[6:4] = 3'b000;
    assign rc[7]  = round_onehot[1]  | round_onehot[2]  | round_onehot[4]  | round_onehot[6]
                  | round_onehot[8]  | round_onehot[9]  | round_onehot[12] | round_onehot[13]
                  | round_onehot[14] | round_onehot[17] | round_onehot[20] | round_onehot[21];
    assign rc[14:8] = '0;
    assign rc[15] = round_onehot[1]  | round_onehot[2]  | round_onehot[3]  | round_onehot[4]
                  | round_onehot[6]  | round_onehot[7]  | round_onehot[10] | round_onehot[12]
                  | round_onehot[14] | round_onehot[15] | round_onehot[16] | round_onehot[18]
                  | round_onehot[20] | round_onehot[21] | round_onehot[23];
    assign rc[30:16] = '0;
    assign rc[31] = round_onehot[3]  | round_onehot[5]  | round_onehot[6]  | round_onehot[10]
                  | round_onehot[11] | round_onehot[12] | round_onehot[19] | round_onehot[20]
                  | round_onehot[22] | round_onehot[23];
    assign rc[62:32] = '0;
    assign rc[63] = round_onehot[2]  | round_onehot[3]  | round_onehot[6]  | round_onehot[7]
                  | round_onehot[13] | round_onehot[14] | round_onehot[15] | round_onehot[16]
                  | round_onehot[17] | round_onehot[19] | round_onehot[20] | round_onehot[21]
                  | round_onehot[23];

    // the round shift register upstream never holds two rounds at once
    always_comb begin
        a_round_onehot: assert #0 ($onehot0(round_onehot))
            else $error("round index is not one-hot: %b", round_onehot);
    end

endmodule

`default_nettype wire

// ==== verilog/keccak_round.sv ====
////////////////////////////////////////////////////////////
// Keccak-f[1600] single round
// theta, rho, pi, chi and iota on the lane view, combinational
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module keccak_round (
    input  wire keccak_pkg::state_u state_in,
    input  wire logic [63:0]        rc,        // iota constant for this round
    output keccak_pkg::state_u      state_out
);

    // rho offsets, indexed x + 5y
    localparam int rot_off [25] = '{
        0,  1,  62, 28, 27,
        36, 44, 6,  55, 20,
        3,  10, 43, 25, 39,
        41, 45, 15, 21, 8,
        18, 2,  61, 56, 14
    };

    logic [63:0] col_par [5];  // theta column parity
    logic [63:0] col_mix [5];  // theta term added to each column
    logic [63:0] pi_lane [25]; // lanes after theta, rho and pi

    // rotate a lane left by n, n = 0 gives the lane back
    function automatic logic [63:0] rotl(input logic [63:0] v, input int n);
        rotl = (v << n) | (v >> ((64 - n) % 64));
    endfunction

    // lane index from column and row, column wraps
    function automatic int lane_at(input int x, input int y);
        lane_at = (x % 5) + 5 * y;
    endfunction

    // pi moves (x, y) to (y, 2x + 3y)
    // so destination (x, y) reads source ((x + 3y) mod 5, x)
    function automatic int pi_src(input int i);
        pi_src = lane_at((i % 5) + 3 * (i / 5), i % 5);
    endfunction

    always_comb begin
        for (int x = 0; x < 5; x++) begin
            col_par[x] = state_in.lane[x] ^ state_in.lane[x + 5] ^ state_in.lane[x + 10]
                       ^ state_in.lane[x + 15] ^ state_in.lane[x + 20];
        end
        for (int x = 0; x < 5; x++) begin
            col_mix[x] = col_par[(x + 4) % 5] ^ rotl(col_par[(x + 1) % 5], 1); // left ^ right rot
        end

        // theta applied on the source lane, then rotated and moved
        for (int i = 0; i < 25; i++) begin
            pi_lane[i] = rotl(state_in.lane[pi_src(i)] ^ col_mix[pi_src(i) % 5],
                              rot_off[pi_src(i)]);
        end

        // chi along each row, iota folded into lane 0
        for (int i = 0; i < 25; i++) begin
            state_out.lane[i] = pi_lane[i]
                              ^ (~pi_lane[lane_at((i % 5) + 1, i / 5)]
                                 & pi_lane[lane_at((i % 5) + 2, i / 5)])
                              ^ ((i == 0) ? rc : 64'd0);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/keccak_permutation.sv ====
////////////////////////////////////////////////////////////
// Keccak-f[1600] permutation
// absorbs a rate block, then 24 rounds at one per cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "keccak_macros.svh"

module keccak_permutation (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire keccak_pkg::block_t block,
    input  wire logic               block_ready,
    input  wire logic               first_block, // absorb into a zero state
    output logic                    ack,
    output keccak_pkg::state_u      state,
    output logic                    out_ready
);

    logic [`KECCAK_ROUNDS-2:0] round_sr;     // rounds 1..23, one-hot
    logic                      calc;         // rounds 1..23 in flight
    logic                      accept;
    logic [`KECCAK_ROUNDS-1:0] round_onehot;
    logic [63:0]               rc;
    keccak_pkg::block_t        block_le;     // block with lanes byte swapped
    logic [`KECCAK_STATE_W-1:0] base;        // state to absorb into
    keccak_pkg::state_u        round_in;
    keccak_pkg::state_u        round_out;

    assign accept = block_ready & ~calc; // round 0 runs in this cycle
    assign ack    = accept;

    // message bytes enter each lane little-endian
    for (genvar k = 0; k < `KECCAK_RATE_W / 64; k++) begin : g_lane
        for (genvar j = 0; j < 8; j++) begin : g_byte
            assign block_le[`KECCAK_RATE_W-1-64*k-8*j -: 8] =
                block[`KECCAK_RATE_W-1-64*k-56+8*j -: 8];
        end
    end

    assign base = first_block ? '0 : state.flat;

    assign round_in.flat = accept
        ? {base[`KECCAK_STATE_W-1 -: `KECCAK_RATE_W] ^ block_le,
           base[`KECCAK_STATE_W-`KECCAK_RATE_W-1:0]}
        : state.flat;

    assign round_onehot = {round_sr, accept};

    keccak_rconst u_rconst (
        .round_onehot (round_onehot),
        .rc           (rc)
    );

    keccak_round u_round (
        .state_in  (round_in),
        .rc        (rc),
        .state_out (round_out)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            round_sr  <= '0;
            calc      <= 1'b0;
            out_ready <= 1'b0;
        end else begin
            round_sr <= {round_sr[`KECCAK_ROUNDS-3:0], accept};
            calc     <= (calc & ~round_sr[`KECCAK_ROUNDS-2]) | accept; // drops after round 23
            if (accept)
                out_ready <= 1'b0;
            else if (round_sr[`KECCAK_ROUNDS-2])
                out_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept | calc)
            state <= round_out;
    end

    // a new block is only taken once the round pipeline has drained
    a_ack_idle: assert property (@(posedge clk) disable iff (reset)
        ack |-> (round_sr == '0))
        else $error("block taken while rounds are in flight");

    // result appears exactly one permutation after its block
    a_ready_after_ack: assert property (@(posedge clk) disable iff (reset)
        $rose(out_ready) |-> $past(ack, `KECCAK_ROUNDS))
        else $error("out_ready rose without a block taken 24 cycles before");

endmodule

`default_nettype wire

// ==== verilog/keccak_padder.sv ====
////////////////////////////////////////////////////////////
// Keccak-512 padder
// credit word buffer, 576-bit block assembly, pad10*1
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "keccak_macros.svh"

module keccak_padder (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  in_valid,
    input  wire keccak_pkg::msg_word_t in_word,
    output logic                       in_credit,   // one credit back per pop
    input  wire logic                  ack,
    output keccak_pkg::block_t         block,
    output logic                       block_ready,
    output logic                       block_last,  // block ends the message
    output logic                       first_block  // block starts a message
);

    localparam int depth  = `KECCAK_IN_CREDITS;
    localparam int ptr_w  = $clog2(depth);
    localparam int words  = `KECCAK_RATE_W / `KECCAK_WORD_W; // 18 per block
    localparam int widx_w = $clog2(words);

    keccak_pkg::msg_word_t     fifo_mem [depth];
    logic [ptr_w-1:0]          wr_ptr;
    logic [ptr_w-1:0]          rd_ptr;
    logic [ptr_w:0]            count;
    logic                      pop;
    keccak_pkg::msg_word_t     head;
    logic [`KECCAK_WORD_W-1:0] byte_mask; // valid bytes of a final word
    logic [`KECCAK_WORD_W-1:0] pad_word;
    logic [widx_w-1:0]         widx;      // next word slot in the block
    keccak_pkg::block_t        next_block;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        ptr_inc = (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head      = fifo_mem[rd_ptr];
    assign pop       = (count != '0) && !block_ready; // hold off while a block waits
    assign in_credit = pop;

    assign byte_mask = ~({`KECCAK_WORD_W{1'b1}} >> {head.byte_num, 3'b000});
    assign pad_word  = head.last
        ? ((head.data & byte_mask)
           | ({8'h01, {(`KECCAK_WORD_W-8){1'b0}}} >> {head.byte_num, 3'b000})) // 0x01 after data
        : head.data;

    always_ff @(posedge clk) begin
        if (in_valid)
            fifo_mem[wr_ptr] <= in_word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            if (in_valid && !pop)
                count <= count + 1'b1;
            else if (!in_valid && pop)
                count <= count - 1'b1;
        end
    end

    // slot write, zero fill after a final word, 0x80 into byte 71
    always_comb begin
        next_block = block;
        for (int k = 0; k < words; k++) begin
            if (k == widx)
                next_block[`KECCAK_RATE_W-1-`KECCAK_WORD_W*k -: `KECCAK_WORD_W] = pad_word;
            else if (head.last && k > widx)
                next_block[`KECCAK_RATE_W-1-`KECCAK_WORD_W*k -: `KECCAK_WORD_W] = '0;
        end
        if (head.last)
            next_block[7:0] = next_block[7:0] | 8'h80; // may merge with 0x01 to 0x81
    end

    always_ff @(posedge clk) begin
        if (pop)
            block <= next_block;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            widx        <= '0;
            block_ready <= 1'b0;
            block_last  <= 1'b0;
            first_block <= 1'b1;
        end else if (ack) begin
            block_ready <= 1'b0;
            first_block <= block_last; // next block opens a new message
        end else if (pop) begin
            if (head.last || widx == widx_w'(words - 1)) begin
                block_ready <= 1'b1;
                block_last  <= head.last;
                widx        <= '0;
            end else begin
                widx <= widx + 1'b1;
            end
        end
    end

    // source must only send against a credit it holds
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (count != depth))
        else $error("message word arrived with the input buffer full");

endmodule

`default_nettype wire

// ==== verilog/keccak_hash.sv ====
////////////////////////////////////////////////////////////
// Keccak-512 hash engine top
// padder into permutation, digest pulse at message end
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "keccak_macros.svh"

module keccak_hash (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   in_valid,
    input  wire keccak_pkg::msg_word_t  in_word,
    output logic                        in_credit,
    output logic [`KECCAK_DIGEST_W-1:0] digest,
    output logic                        digest_valid
);

    keccak_pkg::block_t block;
    logic               block_ready;
    logic               block_last;
    logic               first_block;
    logic               ack;
    keccak_pkg::state_u state;
    logic               out_ready;
    logic               msg_end;     // block in the permutation ends its message
    logic               out_ready_q; // for the rising edge

    keccak_padder u_padder (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_word     (in_word),
        .in_credit   (in_credit),
        .ack         (ack),
        .block       (block),
        .block_ready (block_ready),
        .block_last  (block_last),
        .first_block (first_block)
    );

    keccak_permutation u_perm (
        .clk         (clk),
        .reset       (reset),
        .block       (block),
        .block_ready (block_ready),
        .first_block (first_block),
        .ack         (ack),
        .state       (state),
        .out_ready   (out_ready)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            msg_end     <= 1'b0;
            out_ready_q <= 1'b0;
        end else begin
            out_ready_q <= out_ready;
            if (ack)
                msg_end <= block_last; // latched with the block it belongs to
        end
    end

    // one pulse per message, digest held until the next block is taken
    assign digest_valid = out_ready & ~out_ready_q & msg_end;

    // lanes 0..7 of the state, each a little-endian lane value
    assign digest = state.flat[`KECCAK_STATE_W-1 -: `KECCAK_DIGEST_W];

endmodule

`default_nettype wire

// ==== test/keccak_model.svh ====
////////////////////////////////////////////////////////////
// Keccak-512 reference model for the testbench
// pad10*1, Keccak-f[1600] and digest with plain loops
////////////////////////////////////////////////////////////
`ifndef KECCAK_MODEL_SVH
`define KECCAK_MODEL_SVH

// round constant LFSR, x^8 + x^6 + x^5 + x^4 + 1
function automatic logic lfsr_bit(input int t);
    logic [8:0] r;
    r = 9'd1;
    for (int i = 0; i < t % 255; i++) begin
        r = r << 1;
        if (r[8]) begin
            r = r ^ 9'h171; // feedback taps, drops bit 8
        end
    end
    return r[0];
endfunction

function automatic logic [63:0] round_constant(input int rnd);
    logic [63:0] rc;
    rc = '0;
    for (int j = 0; j < 7; j++) begin
        rc[(1 << j) - 1] = lfsr_bit(j + 7 * rnd); // bit positions 2^j - 1
    end
    return rc;
endfunction

function automatic logic [63:0] rotate_left(input logic [63:0] v, input int n);
    if (n == 0) begin
        return v;
    end
    return (v << n) | (v >> (64 - n));
endfunction

// lanes in the top-first order of the flat state
function automatic logic [`KECCAK_STATE_W-1:0] keccak_f(input logic [`KECCAK_STATE_W-1:0] s);
    logic [63:0] a [25];
    logic [63:0] b [25];
    logic [63:0] c [5];
    int          off [25];
    int          x;
    int          y;
    int          nx;
    off[0] = 0;
    x = 1;
    y = 0;
    for (int t = 0; t < 24; t++) begin
        off[x + 5 * y] = ((t + 1) * (t + 2) / 2) % 64; // rho offsets from the (x, y) walk
        nx = y;
        y  = (2 * x + 3 * y) % 5;
        x  = nx;
    end
    for (int i = 0; i < 25; i++) begin
        a[i] = s[`KECCAK_STATE_W-1-64*i -: 64];
    end
    for (int r = 0; r < `KECCAK_ROUNDS; r++) begin
        for (x = 0; x < 5; x++) begin
            c[x] = a[x] ^ a[x + 5] ^ a[x + 10] ^ a[x + 15] ^ a[x + 20];
        end
        for (x = 0; x < 5; x++) begin
            for (y = 0; y < 5; y++) begin
                a[x + 5 * y] ^= c[(x + 4) % 5] ^ rotate_left(c[(x + 1) % 5], 1);
            end
        end
        for (x = 0; x < 5; x++) begin
            for (y = 0; y < 5; y++) begin
                b[y + 5 * ((2 * x + 3 * y) % 5)] = rotate_left(a[x + 5 * y], off[x + 5 * y]);
            end
        end
        for (x = 0; x < 5; x++) begin
            for (y = 0; y < 5; y++) begin
                a[x + 5 * y] = b[x + 5 * y] ^ (~b[(x + 1) % 5 + 5 * y] & b[(x + 2) % 5 + 5 * y]);
            end
        end
        a[0] ^= round_constant(r);
    end
    for (int i = 0; i < 25; i++) begin
        s[`KECCAK_STATE_W-1-64*i -: 64] = a[i];
    end
    return s;
endfunction

// block blk of the padded message, bytes little-endian within each lane
function automatic logic [`KECCAK_RATE_W-1:0] padded_block(input logic [7:0] m [512],
                                                          input int len, input int blk);
    logic [`KECCAK_RATE_W-1:0] p;
    logic [7:0]                v;
    int                        idx;
    int                        nbytes;
    nbytes = `KECCAK_RATE_W / 8;
    p = '0;
    for (int i = 0; i < nbytes; i++) begin
        idx = nbytes * blk + i;
        if (idx < len) begin
            v = m[idx];
        end else if (idx == len) begin
            v = 8'h01; // first pad bit
        end else begin
            v = 8'h00;
        end
        if (i == nbytes - 1 && blk == len / nbytes) begin
            v = v | 8'h80; // closing pad bit of the last block
        end
        p[`KECCAK_RATE_W - 64 * (i / 8 + 1) + 8 * (i % 8) +: 8] = v;
    end
    return p;
endfunction

function automatic logic [`KECCAK_DIGEST_W-1:0] keccak512(input logic [7:0] m [512],
                                                         input int len);
    logic [`KECCAK_STATE_W-1:0] s;
    s = '0;
    for (int blk = 0; blk <= len / (`KECCAK_RATE_W / 8); blk++) begin
        s[`KECCAK_STATE_W-1 -: `KECCAK_RATE_W] ^= padded_block(m, len, blk);
        s = keccak_f(s);
    end
    return s[`KECCAK_STATE_W-1 -: `KECCAK_DIGEST_W]; // lanes 0..7
endfunction

`endif

// ==== test/keccak_tb.sv ====
////////////////////////////////////////////////////////////
// Keccak-512 engine testbench
// credit source, model digests, concurrent checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "keccak_macros.svh"

module keccak_tb;

    localparam int n_msgs       = 17;
    localparam int reset_cycles = 16;
    localparam int max_stall    = 40; // a block plus its 24 rounds

    logic                        clk;
    logic                        reset;
    logic                        in_valid;
    keccak_pkg::msg_word_t       in_word;
    logic                        in_credit;
    logic [`KECCAK_DIGEST_W-1:0] digest;
    logic                        digest_valid;

    int                          seed = 32'hf7d8d6c6;
    logic [7:0]                  msg_buf [512];
    int                          msg_len [n_msgs];
    bit                          msg_gaps [n_msgs];
    logic [`KECCAK_DIGEST_W-1:0] exp_digest [32];
    logic [`KECCAK_DIGEST_W-1:0] exp_now;          // digest due next
    int                          exp_wr = 0;
    int                          exp_rd = 0;
    int                          credits = 0;      // source side credit count
    int                          cycles = 0;
    int                          cycle_limit = 0;
    int                          stall_cycles = 0;
    logic                        waiting = 1'b0;   // held back for lack of credit
    logic                        seen_valid = 1'b0;

    `include "keccak_model.svh"

    keccak_hash dut_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_word      (in_word),
        .in_credit    (in_credit),
        .digest       (digest),
        .digest_valid (digest_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
            waiting  <= 1'b0;
        end
    endtask

    // always ends in a final word that is empty for len a multiple of 4
    task automatic send_message(input int len, input bit gaps);
        int                    nwords;
        int                    w;
        int                    avail;
        int                    rnd;
        keccak_pkg::msg_word_t word;
        nwords = len / 4 + 1;
        w = 0;
        while (w < nwords) begin
            @(posedge clk);
            avail = credits + int'(in_credit) - int'(in_valid); // credits after this edge
            rnd = $random(seed);
            if (avail > 0 && !(gaps && rnd[1:0] == 2'b00)) begin
                word.data     = {msg_buf[4*w], msg_buf[4*w+1], msg_buf[4*w+2], msg_buf[4*w+3]};
                word.last     = (w == nwords - 1);
                word.byte_num = (w == nwords - 1) ? 2'(len % 4) : 2'd0; // junk past len
                in_valid <= 1'b1;
                in_word  <= word;
                waiting  <= 1'b0;
                w = w + 1;
            end else begin
                in_valid <= 1'b0;
                waiting  <= (avail == 0);
            end
        end
    endtask

    assign exp_now = exp_digest[exp_rd[4:0]];

    always @(posedge clk) begin
        if (reset)
            credits <= `KECCAK_IN_CREDITS;
        else
            credits <= credits + int'(in_credit) - int'(in_valid);
        if (in_valid)
            seen_valid <= 1'b1;
        if (digest_valid)
            exp_rd <= exp_rd + 1;
        stall_cycles <= waiting ? stall_cycles + 1 : 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
            stop_on_error("timeout: digests did not all arrive within the cycle limit");
    end

    a_quiet_start: assert property (@(posedge clk) disable iff (reset)
        !seen_valid |-> (!in_credit && !digest_valid))
        else stop_on_error("credit or digest seen before any message word was sent");

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= `KECCAK_IN_CREDITS)
        else stop_on_error($sformatf("error at %0t: credits got %0d limit %0d",
                                     $time, $sampled(credits), `KECCAK_IN_CREDITS));

    a_stall_short: assert property (@(posedge clk) disable iff (reset)
        stall_cycles <= max_stall)
        else stop_on_error("source waited too long for a credit to come back");

    a_digest_expected: assert property (@(posedge clk) disable iff (reset)
        digest_valid |-> (exp_rd < exp_wr))
        else stop_on_error("digest_valid pulsed with no message outstanding");

    a_digest_value: assert property (@(posedge clk) disable iff (reset)
        digest_valid |-> (digest == exp_now))
        else stop_on_error($sformatf("error at %0t: digest got %h expected %h",
                                     $time, $sampled(digest), $sampled(exp_now)));

    initial begin
        int rnd;
        reset   = 1'b1;
        in_valid = 1'b0;
        in_word  = '0;
        msg_len[0] = 0;   // empty message
        msg_len[1] = 1;
        msg_len[2] = 2;
        msg_len[3] = 3;
        msg_len[4] = 4;
        msg_len[5] = 71;  // 0x01 and 0x80 share a byte
        msg_len[6] = 72;  // extra padding block
        msg_len[7] = 73;
        msg_len[8] = 300; // multi-block burst
        for (int k = 0; k < n_msgs; k++) begin
            msg_gaps[k] = (k > 8);
            if (k > 8) begin
                rnd = $random(seed);
                msg_len[k] = int'(rnd[7:0]);
            end
        end
        cycle_limit = reset_cycles;
        for (int k = 0; k < n_msgs; k++) begin
            cycle_limit += (msg_len[k] / 72 + 1) * 60 + 100;
        end

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        for (int k = 0; k < n_msgs; k++) begin
            for (int i = 0; i < 512; i++) begin
                rnd = $random(seed);
                msg_buf[i] = rnd[7:0];
            end
            exp_digest[exp_wr] = keccak512(msg_buf, msg_len[k]);
            exp_wr = exp_wr + 1;
            send_message(msg_len[k], msg_gaps[k]);
            if (msg_gaps[k]) begin
                rnd = $random(seed);
                idle_cycles(int'(rnd[2:0])); // random gap between messages
            end
        end
        idle_cycles(1);

        while (exp_rd != exp_wr) begin
            @(posedge clk);
        end
        repeat (30) @(posedge clk); // room for a stray extra digest

        if (exp_rd == n_msgs) begin
            $display("Simulation passed");
            $finish;
        end else begin
            stop_on_error("digest count does not match the number of messages sent");
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
+incdir+test
verilog/keccak_pkg.sv
verilog/keccak_rconst.sv
verilog/keccak_round.sv
verilog/keccak_permutation.sv
verilog/keccak_padder.sv
verilog/keccak_hash.sv
test/keccak_tb.sv
